// ==== bundle_skid.sv ====
`timescale 1ns/10ps
`default_nettype none

module bundle_skid #(
    parameter int WIDTH = 2 * decode_ctrl_pkg::BUNDLE_W
) (
    input  wire              i_clk,
    input  wire              i_rst_n,
    input  wire              i_input_valid,
    output logic             o_input_ready,
    input  wire  [WIDTH-1:0] i_input_data,
    output logic             o_output_valid,
    input  wire              i_output_ready,
    output logic [WIDTH-1:0] o_output_data
);
    // output stage
    logic             out_valid;
    logic [WIDTH-1:0] out_data;
    // overflow stage, used only while the output stalls
    logic             skid_valid;
    logic [WIDTH-1:0] skid_data;

    logic accept;
    logic out_free;

    // ready is the inverted skid flag, so it comes from a flop
    assign accept   = i_input_valid && !skid_valid;
    // output register empty or being taken this edge
    assign out_free = !out_valid || i_output_ready;

    // control flags, i_rst_n high clears them
    always_ff @(posedge i_clk) begin
        if (i_rst_n) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (out_free) begin
            // waiting pair drains first, fetch is held off meanwhile
            out_valid  <= skid_valid || accept;
            skid_valid <= 1'b0;
        end else if (accept) begin
            // output stalled, park the new pair
            skid_valid <= 1'b1;
        end
    end

    // payload
    always_ff @(posedge i_clk) begin
        if (out_free) begin
            out_data <= skid_valid ? skid_data : i_input_data;
        end
        if (accept && !out_free) begin
            skid_data <= i_input_data;
        end
    end

    assign o_input_ready  = !skid_valid;
    assign o_output_valid = out_valid;
    assign o_output_data  = out_data;
endmodule

`default_nettype wire

// ==== decode_ctrl_pkg.sv ====
`default_nettype none

package decode_ctrl_pkg;

    // immediate and packed register addresses
    typedef logic [31:0] xlen_t;
    // {rd, rs2, rs1}, rs1 in the low bits
    typedef logic [14:0] raddr_t;

    // one-hot backend select, bits 3:2 kept for other units
    typedef logic [3:0] pipe_sel_t;
    localparam pipe_sel_t PIPE_XARITH = 4'b0001;
    localparam pipe_sel_t PIPE_XLOGIC = 4'b0010;

    // xarith controls: opsel in 1:0
    typedef logic [4:0] xarith_ctrl_t;
    localparam int XARITH_SUB_BIT      = 2;
    localparam int XARITH_UNSIGNED_BIT = 3;
    localparam int XARITH_WORD_BIT     = 4;
    localparam logic [1:0] XARITH_OP_ADD = 2'd0;
    localparam logic [1:0] XARITH_OP_SLT = 2'd1;

    // xlogic controls: opsel in 2:0
    typedef logic [3:0] xlogic_ctrl_t;
    localparam int XLOGIC_WORD_BIT = 3;
    localparam logic [2:0] XLOGIC_OP_AND = 3'd0;
    localparam logic [2:0] XLOGIC_OP_OR  = 3'd1;
    localparam logic [2:0] XLOGIC_OP_XOR = 3'd2;
    localparam logic [2:0] XLOGIC_OP_SHF = 3'd3;

    // bundle, low to high: legal, raddr, imm, pipe, xarith, xlogic
    localparam int BUNDLE_W = 61;
    typedef logic [BUNDLE_W-1:0] bundle_t;

endpackage

`default_nettype wire

// ==== decoded_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface decoded_if;
    import decode_ctrl_pkg::*;

    // one decoded instruction
    logic         legal;
    raddr_t       raddr;
    xlen_t        imm;
    pipe_sel_t    pipe;
    xarith_ctrl_t xarith;
    xlogic_ctrl_t xlogic;

    // decoder side
    modport producer (output legal, raddr, imm, pipe, xarith, xlogic);
    // bundle packing side
    modport consumer (input legal, raddr, imm, pipe, xarith, xlogic);
endinterface

`default_nettype wire

// ==== dual_decode.f ====
+incdir+.
rv_isa_pkg.sv
decode_ctrl_pkg.sv
decoded_if.sv
rv_inst_decode.sv
bundle_skid.sv
dual_decode.sv
tb_dual_decode.sv

// ==== dual_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module dual_decode (
    input  wire                      i_clk,
    input  wire                      i_rst_n,
    // fetch side
    output logic                     o_input_ready,
    input  wire                      i_input_valid,
    input  wire rv_isa_pkg::inst_t   i_inst0,
    input  wire rv_isa_pkg::inst_t   i_inst1,
    // issue side
    input  wire                      i_output_ready,
    output logic                     o_output_valid,
    output decode_ctrl_pkg::bundle_t o_bundle0,
    output decode_ctrl_pkg::bundle_t o_bundle1
);
    import decode_ctrl_pkg::*;

    // one decoded result per slot
    decoded_if slot0_if ();
    decoded_if slot1_if ();

    rv_inst_decode decode0_i (.i_inst(i_inst0), .dec(slot0_if.producer));
    rv_inst_decode decode1_i (.i_inst(i_inst1), .dec(slot1_if.producer));

    bundle_t bundle0_in;
    bundle_t bundle1_in;

    // legal sits in bit 0, xlogic on top
    assign bundle0_in = {slot0_if.consumer.xlogic, slot0_if.consumer.xarith,
                         slot0_if.consumer.pipe, slot0_if.consumer.imm,
                         slot0_if.consumer.raddr, slot0_if.consumer.legal};
    assign bundle1_in = {slot1_if.consumer.xlogic, slot1_if.consumer.xarith,
                         slot1_if.consumer.pipe, slot1_if.consumer.imm,
                         slot1_if.consumer.raddr, slot1_if.consumer.legal};

    // pair moves as one word, slot 1 in the upper half
    logic [2*BUNDLE_W-1:0] pair_out;

    bundle_skid #(
        .WIDTH(2 * BUNDLE_W)
    ) skid_i (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .i_input_valid(i_input_valid),
        .o_input_ready(o_input_ready),
        .i_input_data({bundle1_in, bundle0_in}),
        .o_output_valid(o_output_valid),
        .i_output_ready(i_output_ready),
        .o_output_data(pair_out)
    );

    assign o_bundle0 = pair_out[BUNDLE_W-1:0];
    assign o_bundle1 = pair_out[2*BUNDLE_W-1:BUNDLE_W];
endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dual decode testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/10ps -f dual_decode.f \
    --top-module tb_dual_decode -o tb_dual_decode \
    && ./obj_dir/tb_dual_decode | grep "Testbench passed" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== rv_inst_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module rv_inst_decode (
    input  wire rv_isa_pkg::inst_t i_inst,
    decoded_if.producer            dec
);
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    // instruction fields
    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;

    assign opcode = i_inst[OPC_LSB +: 5];
    assign funct3 = i_inst[F3_LSB +: 3];
    assign funct7 = i_inst[F7_LSB +: 7];
    assign rd     = i_inst[RD_LSB +: 5];
    assign rs1    = i_inst[RS1_LSB +: 5];
    assign rs2    = i_inst[RS2_LSB +: 5];

    // group qualifiers for the four integer opcodes
    logic is_imm;
    logic is_word;
    // rv64 shifts by immediate use a 6-bit shamt, so only funct7[6:1] is checked
    logic f6_base;
    logic f6_shift;
    logic f7_base;
    logic f7_either;

    assign is_imm    = (opcode == OPC_OP_IMM) || (opcode == OPC_OP_IMM_32);
    assign is_word   = (opcode == OPC_OP_IMM_32) || (opcode == OPC_OP_32);
    assign f6_base   = funct7[6:1] == F7_BASE[6:1];
    assign f6_shift  = f6_base || (funct7[6:1] == F7_ALT[6:1]);
    assign f7_base   = funct7 == F7_BASE;
    assign f7_either = f7_base || (funct7 == F7_ALT);

    // decoded controls before the legality gate
    logic         legal;
    pipe_sel_t    pipe;
    xarith_ctrl_t xarith;
    xlogic_ctrl_t xlogic;

    always_comb begin
        legal  = 1'b0;
        pipe   = '0;
        xarith = '0;
        xlogic = '0;

        case (opcode)
            // addi..andi, addiw..sraiw, add..and, addw..sraw
            OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32: begin
                case (funct3)
                    // sub exists only in the register add forms
                    F3_ADD: begin
                        legal = is_imm || f7_either;
                        pipe = PIPE_XARITH;
                        xarith[1:0] = XARITH_OP_ADD;
                        xarith[XARITH_SUB_BIT] = !is_imm && funct7[5];
                        xarith[XARITH_WORD_BIT] = is_word;
                    end
                    // sll / slli / sllw / slliw
                    F3_SLL: begin
                        legal = (is_imm && !is_word) ? f6_base : f7_base;
                        pipe = PIPE_XLOGIC;
                        xlogic[2:0] = XLOGIC_OP_SHF;
                        xlogic[XLOGIC_WORD_BIT] = is_word;
                    end
                    // set-less-than has no word form
                    F3_SLT, F3_SLTU: begin
                        legal = !is_word;
                        pipe = PIPE_XARITH;
                        xarith[1:0] = XARITH_OP_SLT;
                        xarith[XARITH_UNSIGNED_BIT] = funct3[0];
                    end
                    // logical or arithmetic right shifts
                    F3_SR: begin
                        legal = (is_imm && !is_word) ? f6_shift : f7_either;
                        pipe = PIPE_XLOGIC;
                        xlogic[2:0] = XLOGIC_OP_SHF;
                        xlogic[XLOGIC_WORD_BIT] = is_word;
                    end
                    F3_XOR: begin
                        legal = !is_word;
                        pipe = PIPE_XLOGIC;
                        xlogic[2:0] = XLOGIC_OP_XOR;
                    end
                    F3_OR: begin
                        legal = !is_word;
                        pipe = PIPE_XLOGIC;
                        xlogic[2:0] = XLOGIC_OP_OR;
                    end
                    F3_AND: begin
                        legal = !is_word;
                        pipe = PIPE_XLOGIC;
                        xlogic[2:0] = XLOGIC_OP_AND;
                    end
                endcase
            end
            // lui and auipc add imm to zero or pc in xarith
            OPC_LUI, OPC_AUIPC: begin
                legal = 1'b1;
                pipe = PIPE_XARITH;
                xarith[1:0] = XARITH_OP_ADD;
            end
            // anything else is not handled here
            default: begin
                legal = 1'b0;
            end
        endcase

        // illegal encodings carry no backend controls
        if (!legal) begin
            pipe   = '0;
            xarith = '0;
            xlogic = '0;
        end
    end

    // immediate per format
    xlen_t imm;

    always_comb begin
        case (opcode)
            // sign-extended i-type
            OPC_OP_IMM, OPC_OP_IMM_32: imm = {{20{i_inst[31]}}, i_inst[31:20]};
            // u-type with the low 12 bits clear
            OPC_LUI, OPC_AUIPC: imm = {i_inst[31:12], 12'b0};
            default: imm = '0;
        endcase
    end

    // register addresses come straight from the word
    assign dec.raddr  = {rd, rs2, rs1};
    assign dec.imm    = imm;
    assign dec.legal  = legal;
    assign dec.pipe   = pipe;
    assign dec.xarith = xarith;
    assign dec.xlogic = xlogic;
endmodule

`default_nettype wire

// ==== rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

    // raw instruction word and its fields
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // lsb position of each field in the word
    localparam int OPC_LSB = 2;
    localparam int RD_LSB  = 7;
    localparam int F3_LSB  = 12;
    localparam int RS1_LSB = 15;
    localparam int RS2_LSB = 20;
    localparam int F7_LSB  = 25;

    // major opcodes, bits 6:2 (bits 1:0 are 2'b11 for 32-bit encodings)
    localparam opcode_t OPC_OP_IMM    = 5'b00100;
    localparam opcode_t OPC_AUIPC     = 5'b00101;
    localparam opcode_t OPC_OP_IMM_32 = 5'b00110;
    localparam opcode_t OPC_OP        = 5'b01100;
    localparam opcode_t OPC_LUI       = 5'b01101;
    localparam opcode_t OPC_OP_32     = 5'b01110;

    // funct3 of the integer groups
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct7, alt selects sub / sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

endpackage

`default_nettype wire

// ==== tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

// pack one expected bundle, controls only for legal encodings
function automatic bundle_t pack_bundle(input logic ok, input inst_t w, input xlen_t imm,
                                        input logic arith, input xarith_ctrl_t xa,
                                        input xlogic_ctrl_t xl);
    pipe_sel_t    p;
    xarith_ctrl_t xa_out;
    xlogic_ctrl_t xl_out;
    p = '0;
    xa_out = '0;
    xl_out = '0;
    if (ok && arith) begin
        p = PIPE_XARITH;
        xa_out = xa;
    end else if (ok) begin
        p = PIPE_XLOGIC;
        xl_out = xl;
    end
    // raddr is {rd, rs2, rs1}
    return {xl_out, xa_out, p, imm, w[11:7], w[24:20], w[19:15], ok};
endfunction

// expected bundle for one instruction word
function automatic bundle_t model_bundle(input inst_t w);
    opcode_t    op;
    funct3_t    f3;
    funct7_t    f7;
    logic       reg_form;
    logic       wd;
    logic       ok;
    logic       arith;
    logic       sub;
    logic       uns;
    logic [2:0] sel;
    xlen_t      imm;
    op = w[6:2];
    f3 = w[14:12];
    f7 = w[31:25];
    ok = 1'b0;
    arith = 1'b0;
    sub = 1'b0;
    uns = 1'b0;
    sel = 3'd0;
    imm = '0;
    // op / op-32 have opcode bit 3 set, the 32-bit groups bit 1
    reg_form = op[3];
    wd = op[1];
    if (op == OPC_LUI || op == OPC_AUIPC) begin
        ok = 1'b1;
        arith = 1'b1;
        wd = 1'b0;
        imm = {w[31:12], 12'h000};
    end else if (op inside {OPC_OP_IMM, OPC_OP_IMM_32, OPC_OP, OPC_OP_32}) begin
        if (!reg_form) begin
            imm = {{20{w[31]}}, w[31:20]};
        end
        case (f3)
            F3_ADD: begin
                ok = !reg_form || ((f7 & 7'h5f) == 7'h00);
                arith = 1'b1;
                sub = reg_form && f7[5];
            end
            // 64-bit immediate shifts take a 6-bit shamt
            F3_SLL: begin
                ok = (reg_form || wd) ? (f7 == 7'h00) : (f7[6:1] == 6'h00);
                sel = XLOGIC_OP_SHF;
            end
            F3_SLT, F3_SLTU: begin
                ok = !wd;
                arith = 1'b1;
                sel = {1'b0, XARITH_OP_SLT};
                uns = f3[0];
            end
            F3_SR: begin
                ok = (reg_form || wd) ? ((f7 & 7'h5f) == 7'h00) : ((f7 & 7'h5e) == 7'h00);
                sel = XLOGIC_OP_SHF;
            end
            F3_XOR: begin
                ok = !wd;
                sel = XLOGIC_OP_XOR;
            end
            F3_OR: begin
                ok = !wd;
                sel = XLOGIC_OP_OR;
            end
            default: begin
                ok = !wd;
                sel = XLOGIC_OP_AND;
            end
        endcase
    end
    return pack_bundle(ok, w, imm, arith, {wd, uns, sub, sel[1:0]}, {wd, sel});
endfunction

// legal encoding of a kept opcode, r gives operands, s the choices
function automatic inst_t make_legal(input logic [31:0] r, input logic [31:0] s);
    inst_t   w;
    opcode_t op;
    funct3_t f3;
    funct7_t f7;
    logic    imm_form;
    logic    wd;
    case (s[2:0])
        3'd0, 3'd7: op = OPC_OP_IMM;
        3'd1: op = OPC_OP_IMM_32;
        3'd2, 3'd6: op = OPC_OP;
        3'd3: op = OPC_OP_32;
        3'd4: op = OPC_LUI;
        default: op = OPC_AUIPC;
    endcase
    w = {r[31:7], op, 2'b11};
    if (op != OPC_LUI && op != OPC_AUIPC) begin
        imm_form = (op == OPC_OP_IMM) || (op == OPC_OP_IMM_32);
        wd = (op == OPC_OP_IMM_32) || (op == OPC_OP_32);
        f3 = s[5:3];
        // word groups only have add, sll and the right shifts
        if (wd) begin
            f3 = (s[4:3] == 2'd0) ? F3_ADD : ((s[4:3] == 2'd1) ? F3_SLL : F3_SR);
        end
        f7 = r[31:25];
        if (f3 == F3_SLL) begin
            f7 = (imm_form && !wd) ? {6'h00, r[25]} : 7'h00;
        end else if (f3 == F3_SR) begin
            f7 = (imm_form && !wd) ? {1'b0, s[8], 4'h0, r[25]} : {1'b0, s[8], 5'h00};
        end else if (!imm_form) begin
            f7 = (f3 == F3_ADD) ? {1'b0, s[8], 5'h00} : 7'h00;
        end
        w[31:25] = f7;
        w[14:12] = f3;
    end
    return w;
endfunction

`endif

// ==== tb_dual_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_dual_decode;
    import rv_isa_pkg::*;
    import decode_ctrl_pkg::*;

    `include "tb_decode_model.svh"

    // pairs per test
    // watchdog budget scales with the total
    localparam int N_LEGAL = 300;
    localparam int N_RAW = 300;
    localparam int N_MIXED = 200;
    localparam int N_HOLD = 12;
    localparam int TOTAL_PAIRS = N_LEGAL + N_RAW + N_MIXED + N_HOLD;

    logic    i_clk = 1'b0;
    logic    i_rst_n;
    logic    i_input_valid;
    logic    o_input_ready;
    inst_t   i_inst0;
    inst_t   i_inst1;
    logic    i_output_ready;
    logic    o_output_valid;
    bundle_t o_bundle0;
    bundle_t o_bundle1;

    int seed = 32'h2896_0b7d;
    int errors = 0;
    int checks = 0;
    int tests = 0;
    int cycle = 0;
    // mode 1 randomizes i_output_ready every cycle
    int ready_mode = 0;
    // set in the full rate phase where latency must be one cycle
    logic strict = 1'b0;
    // expected pairs with slot 1 in the upper half
    logic [2*BUNDLE_W-1:0] exp_q[$];
    int acc_q[$];
    logic prev_stall = 1'b0;
    bundle_t prev_b0;
    bundle_t prev_b1;

    dual_decode dut_i (
        .i_clk(i_clk),
        .i_rst_n(i_rst_n),
        .o_input_ready(o_input_ready),
        .i_input_valid(i_input_valid),
        .i_inst0(i_inst0),
        .i_inst1(i_inst1),
        .i_output_ready(i_output_ready),
        .o_output_valid(o_output_valid),
        .o_bundle0(o_bundle0),
        .o_bundle1(o_bundle1)
    );

    initial begin
        forever #4 i_clk = ~i_clk;
    end

    initial begin
        #(TOTAL_PAIRS * 20 * 8);
        $display("Timeout: run did not finish within %0d ns", TOTAL_PAIRS * 20 * 8);
        $display("Testbench failed");
        $finish;
    end

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, exp, got);
        end
    endtask

    task automatic check_bundle(input string name, input bundle_t exp, input bundle_t got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // monitor runs on the falling edge between drive points
    always @(negedge i_clk) begin
        logic [2*BUNDLE_W-1:0] exp_pair;
        int acc;
        cycle++;
        if (i_rst_n) begin
            // reset is active high
            check_bit("o_output_valid", 1'b0, o_output_valid);
            check_bit("o_input_ready", 1'b1, o_input_ready);
            prev_stall = 1'b0;
        end else begin
            // stalled output must hold
            if (prev_stall) begin
                check_bit("o_output_valid", 1'b1, o_output_valid);
                check_bundle("o_bundle0", prev_b0, o_bundle0);
                check_bundle("o_bundle1", prev_b1, o_bundle1);
            end
            if (o_output_valid && i_output_ready) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("Error at %0t: a pair left the DUT with none pending", $time);
                end else begin
                    exp_pair = exp_q.pop_front();
                    acc = acc_q.pop_front();
                    check_bundle("o_bundle0", exp_pair[BUNDLE_W-1:0], o_bundle0);
                    check_bundle("o_bundle1", exp_pair[2*BUNDLE_W-1:BUNDLE_W], o_bundle1);
                    if (strict && cycle != acc + 1) begin
                        errors++;
                        $display("Error at %0t: latency expected 1, got %0d", $time, cycle - acc);
                    end
                end
            end
            if (strict) begin
                check_bit("o_input_ready", 1'b1, o_input_ready);
            end
            if (i_input_valid && o_input_ready) begin
                exp_q.push_back({model_bundle(i_inst1), model_bundle(i_inst0)});
                acc_q.push_back(cycle);
            end
            prev_stall = o_output_valid && !i_output_ready;
            prev_b0 = o_bundle0;
            prev_b1 = o_bundle1;
        end
    end

    // advance to 1 ns after the next rising edge
    task automatic tick();
        logic [31:0] r;
        @(posedge i_clk);
        #1;
        if (ready_mode == 1) begin
            r = $random(seed);
            i_output_ready = r[0];
        end
    endtask

    // mode 0 gives legal words and mode 1 raw words while mode 2 mixes them
    task automatic pick_inst(input int mode, output inst_t w);
        logic [31:0] r;
        logic [31:0] s;
        r = $random(seed);
        s = $random(seed);
        if (mode == 1 || (mode == 2 && s[31])) begin
            w = r;
        end else begin
            w = make_legal(r, s);
        end
    endtask

    task automatic load_pair(input int mode);
        pick_inst(mode, i_inst0);
        pick_inst(mode, i_inst1);
        i_input_valid = 1'b1;
    endtask

    // hold the offered pair until an edge takes it
    task automatic wait_accept();
        logic go;
        go = 1'b0;
        while (!go) begin
            @(negedge i_clk);
            go = o_input_ready;
            tick();
        end
    endtask

    task automatic send_pairs(input int n, input int mode);
        repeat (n) begin
            load_pair(mode);
            wait_accept();
        end
    endtask

    task automatic drain();
        i_input_valid = 1'b0;
        while (exp_q.size() != 0) begin
            tick();
        end
        tick();
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests++;
        $display("%s: done, %0d errors", name, errors - start_errors);
    endtask

    initial begin
        int start;
        logic go;
        i_rst_n = 1'b1;
        i_input_valid = 1'b0;
        i_inst0 = '0;
        i_inst1 = '0;
        i_output_ready = 1'b1;

        // reset and the first idle cycle after it
        start = errors;
        repeat (4) @(posedge i_clk);
        #1;
        i_rst_n = 1'b0;
        @(negedge i_clk);
        check_bit("o_output_valid", 1'b0, o_output_valid);
        check_bit("o_input_ready", 1'b1, o_input_ready);
        tick();
        end_test("reset", start);

        start = errors;
        strict = 1'b1;
        send_pairs(N_LEGAL, 0);
        drain();
        strict = 1'b0;
        end_test("legal stream", start);

        start = errors;
        send_pairs(N_RAW, 1);
        drain();
        end_test("random words", start);

        start = errors;
        ready_mode = 1;
        send_pairs(N_MIXED, 2);
        drain();
        ready_mode = 0;
        i_output_ready = 1'b1;
        end_test("random ready", start);

        // issue stalled for 10 cycles while fetch keeps offering
        start = errors;
        i_output_ready = 1'b0;
        load_pair(0);
        for (int c = 0; c < 10; c++) begin
            @(negedge i_clk);
            go = o_input_ready;
            if (c >= 2) begin
                check_bit("o_input_ready", 1'b0, o_input_ready);
                checks++;
                if (exp_q.size() != 2) begin
                    errors++;
                    $display("Error at %0t: pairs held expected 2, got %0d", $time, exp_q.size());
                end
            end
            tick();
            if (go) begin
                load_pair(0);
            end
        end
        i_output_ready = 1'b1;
        wait_accept();
        send_pairs(N_HOLD - 3, 0);
        drain();
        end_test("back-pressure", start);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end
endmodule

`default_nettype wire
